/* verilog/bypass_pkg.sv */
package bypass_pkg;

    // ------------------------------------------------------------
    // ports and stream beat.
    // ------------------------------------------------------------
    localparam int num_ports = 2;

    typedef logic [1:0] port_t;

    // tdest code that marks a packet for discard.
    localparam port_t port_drop = 2'd3;

    localparam int fifo_depth = 16;
    localparam int fifo_aw = $clog2(fifo_depth);

    typedef struct packed {
        logic [63:0] tdata;
        logic [7:0]  tkeep;
        logic        tlast;
        port_t       tid;
        port_t       tdest;
    } axis_beat_t;

    // ------------------------------------------------------------
    // register map.
    // ------------------------------------------------------------
    localparam int reg_addr_w = 5;
    localparam int reg_data_w = 32;
    localparam logic [1:0] resp_okay = 2'b00;

    typedef enum logic [reg_addr_w-1:0] {
        reg_config = 5'h00,
        reg_drop0  = 5'h04,
        reg_drop1  = 5'h08,
        reg_loop0  = 5'h0c,
        reg_loop1  = 5'h10
    } reg_addr_e;

    // bit 1 drop_pkt_loop, bit 0 switch_paths.
    typedef struct packed {
        logic drop_pkt_loop;
        logic switch_paths;
    } bypass_cfg_t;

    typedef enum logic [1:0] {drop_idle, drop_pass, drop_discard} drop_state_e;
    typedef enum logic {mux_idle, mux_busy} mux_state_e;

endpackage

/* verilog/bypass_regs.sv */
`timescale 1ns/100ps

module bypass_regs import bypass_pkg::*; (
    input  logic                  core_clk,
    input  logic                  rst,

    input  logic [reg_addr_w-1:0] awaddr,
    input  logic                  awvalid,
    output logic                  awready,
    input  logic [reg_data_w-1:0] wdata,
    input  logic [3:0]            wstrb,
    input  logic                  wvalid,
    output logic                  wready,
    output logic [1:0]            bresp,
    output logic                  bvalid,
    input  logic                  bready,
    input  logic [reg_addr_w-1:0] araddr,
    input  logic                  arvalid,
    output logic                  arready,
    output logic [reg_data_w-1:0] rdata,
    output logic [1:0]            rresp,
    output logic                  rvalid,
    input  logic                  rready,

    input  logic [num_ports-1:0]  drop_evt,
    input  logic [num_ports-1:0]  loop_evt,
    output bypass_cfg_t           cfg
);

    logic                  aw_held;
    logic                  w_held;
    logic [reg_addr_w-1:0] aw_addr_q;
    logic [reg_data_w-1:0] w_data_q;
    logic [3:0]            w_strb_q;
    logic                  do_write;
    logic [reg_data_w-1:0] rd_val;
    logic [31:0]           drop_cnt [num_ports];
    logic [31:0]           loop_cnt [num_ports];

    // ------------------------------------------------------------
    // write channel.
    // ------------------------------------------------------------
    assign awready  = !aw_held;
    assign wready   = !w_held;
    assign bresp    = resp_okay;
    assign do_write = aw_held && w_held && !bvalid;

    always_ff @(posedge core_clk) begin
        if (rst) begin
            aw_held <= 1'b0;
            w_held  <= 1'b0;
            bvalid  <= 1'b0;
            cfg     <= '0;
        end else begin
            if (awvalid && awready) begin
                aw_held   <= 1'b1;
                aw_addr_q <= awaddr;
            end
            if (wvalid && wready) begin
                w_held   <= 1'b1;
                w_data_q <= wdata;
                w_strb_q <= wstrb;
            end
            if (bvalid && bready) begin
                bvalid <= 1'b0;
            end
            // only the config register is writable.
            if (do_write) begin
                aw_held <= 1'b0;
                w_held  <= 1'b0;
                bvalid  <= 1'b1;
                if (aw_addr_q == reg_config && w_strb_q[0]) begin
                    cfg <= bypass_cfg_t'(w_data_q[1:0]);
                end
            end
        end
    end

    // ------------------------------------------------------------
    // read channel.
    // ------------------------------------------------------------
    always_comb begin
        case (araddr)
            reg_config: rd_val = {30'd0, cfg};
            reg_drop0:  rd_val = drop_cnt[0];
            reg_drop1:  rd_val = drop_cnt[1];
            reg_loop0:  rd_val = loop_cnt[0];
            reg_loop1:  rd_val = loop_cnt[1];
            default:    rd_val = '0;
        endcase
    end

    assign rresp = resp_okay;

    // arready comes one cycle after arvalid, rvalid one cycle after that.
    always_ff @(posedge core_clk) begin
        if (rst) begin
            arready <= 1'b0;
            rvalid  <= 1'b0;
        end else begin
            arready <= arvalid && !arready && !rvalid;
            if (arvalid && arready) begin
                rvalid <= 1'b1;
                rdata  <= rd_val;
            end else if (rvalid && rready) begin
                rvalid <= 1'b0;
            end
        end
    end

    // saturating drop counters.
    always_ff @(posedge core_clk) begin
        if (rst) begin
            for (int i = 0; i < num_ports; i++) begin
                drop_cnt[i] <= '0;
                loop_cnt[i] <= '0;
            end
        end else begin
            for (int i = 0; i < num_ports; i++) begin
                if (drop_evt[i] && drop_cnt[i] != '1) drop_cnt[i] <= drop_cnt[i] + 1'b1;
                if (loop_evt[i] && loop_cnt[i] != '1) loop_cnt[i] <= loop_cnt[i] + 1'b1;
            end
        end
    end

    a_bvalid_after_pair: assert property (@(posedge core_clk) disable iff (rst)
        $rose(bvalid) |-> $past(aw_held && w_held));

endmodule

/* verilog/pkt_drop.sv */
`timescale 1ns/100ps

module pkt_drop import bypass_pkg::*; (
    input  logic       core_clk,
    input  logic       rst,

    input  axis_beat_t in_beat,
    input  logic       in_valid,
    output logic       in_ready,

    input  logic       drop_pkt,

    output axis_beat_t out_beat,
    output logic       out_valid,
    input  logic       out_ready,

    output logic       drop_evt
);

    drop_state_e state;
    logic        discard_now;
    logic        in_xfer;

    // drop_pkt only counts while waiting on a first beat.
    always_comb begin
        case (state)
            drop_idle:    discard_now = drop_pkt;
            drop_discard: discard_now = 1'b1;
            default:      discard_now = 1'b0;
        endcase
    end

    // discarded beats are swallowed at full rate.
    assign in_ready  = discard_now ? 1'b1 : out_ready;
    assign out_valid = in_valid && !discard_now;
    assign out_beat  = in_beat;
    assign in_xfer   = in_valid && in_ready;

    // one pulse per discarded packet, on its first beat.
    assign drop_evt = in_valid && drop_pkt && (state == drop_idle);

    always_ff @(posedge core_clk) begin
        if (rst) begin
            state <= drop_idle;
        end else if (in_xfer) begin
            if (in_beat.tlast) begin
                state <= drop_idle;
            end else if (state == drop_idle) begin
                state <= drop_pkt ? drop_discard : drop_pass;
            end
        end
    end

endmodule

/* verilog/pkt_fifo.sv */
`timescale 1ns/100ps

module pkt_fifo import bypass_pkg::*; (
    input  logic       core_clk,
    input  logic       rst,

    input  axis_beat_t in_beat,
    input  logic       in_valid,
    output logic       in_ready,

    output axis_beat_t out_beat,
    output logic       out_valid,
    input  logic       out_ready
);

    axis_beat_t         mem [fifo_depth];
    logic [fifo_aw-1:0] wr_ptr;
    logic [fifo_aw-1:0] rd_ptr;
    logic [fifo_aw:0]   count;
    logic               wr_en;
    logic               rd_en;

    assign in_ready  = (count != fifo_depth);
    assign out_valid = (count != 0);
    assign out_beat  = mem[rd_ptr];

    assign wr_en = in_valid && in_ready;
    assign rd_en = out_valid && out_ready;

    always_ff @(posedge core_clk) begin
        if (wr_en) begin
            mem[wr_ptr] <= in_beat;
        end
    end

    // pointers wrap naturally at the power-of-two depth.
    always_ff @(posedge core_clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_en) wr_ptr <= wr_ptr + 1'b1;
            if (rd_en) rd_ptr <= rd_ptr + 1'b1;
            case ({wr_en, rd_en})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // a write must never land on the oldest unread word.
    a_no_write_full: assert property (@(posedge core_clk) disable iff (rst)
        wr_en |-> !(wr_ptr == rd_ptr && count != 0));

endmodule

/* verilog/bypass_path.sv */
`timescale 1ns/100ps

module bypass_path import bypass_pkg::*; (
    input  logic        core_clk,
    input  logic        rst,
    input  bypass_cfg_t cfg,

    input  axis_beat_t  in_beat,
    input  logic        in_valid,
    output logic        in_ready,

    output axis_beat_t  own_beat,
    output logic        own_valid,
    input  logic        own_ready,

    output axis_beat_t  cross_beat,
    output logic        cross_valid,
    input  logic        cross_ready,

    output logic        drop_evt,
    output logic        loop_evt
);

    axis_beat_t code_beat, fifo_beat, rw_beat, filt_beat;
    logic       code_valid, code_ready;
    logic       fifo_valid, fifo_ready;
    logic       filt_valid, filt_ready;
    logic       code_drop, loop_drop;
    logic       sel_held, sel_q, sel;

    // ------------------------------------------------------------
    // DROP code filter and buffer.
    // ------------------------------------------------------------
    assign code_drop = (in_beat.tdest == port_drop);

    pkt_drop u_code_drop (
        .core_clk, .rst,
        .in_beat   (in_beat),    .in_valid  (in_valid),   .in_ready  (in_ready),
        .drop_pkt  (code_drop),
        .out_beat  (code_beat),  .out_valid (code_valid), .out_ready (code_ready),
        .drop_evt  (drop_evt)
    );

    pkt_fifo u_fifo (
        .core_clk, .rst,
        .in_beat   (code_beat),  .in_valid  (code_valid), .in_ready  (code_ready),
        .out_beat  (fifo_beat),  .out_valid (fifo_valid), .out_ready (fifo_ready)
    );

    // ------------------------------------------------------------
    // loop check on the incoming tdest, then rewrite tdest to tid.
    // ------------------------------------------------------------
    assign loop_drop = cfg.drop_pkt_loop && (fifo_beat.tdest == fifo_beat.tid);

    always_comb begin
        rw_beat       = fifo_beat;
        rw_beat.tdest = fifo_beat.tid;
    end

    pkt_drop u_loop_drop (
        .core_clk, .rst,
        .in_beat   (rw_beat),    .in_valid  (fifo_valid), .in_ready  (fifo_ready),
        .drop_pkt  (loop_drop),
        .out_beat  (filt_beat),  .out_valid (filt_valid), .out_ready (filt_ready),
        .drop_evt  (loop_evt)
    );

    // select is taken when a first beat shows up and held to tlast.
    always_ff @(posedge core_clk) begin
        if (rst) begin
            sel_held <= 1'b0;
        end else if (filt_valid && filt_ready && filt_beat.tlast) begin
            sel_held <= 1'b0;
        end else if (filt_valid && !sel_held) begin
            sel_held <= 1'b1;
            sel_q    <= cfg.switch_paths;
        end
    end

    assign sel = sel_held ? sel_q : cfg.switch_paths;

    assign own_beat    = filt_beat;
    assign cross_beat  = filt_beat;
    assign own_valid   = filt_valid && !sel;
    assign cross_valid = filt_valid && sel;
    assign filt_ready  = sel ? cross_ready : own_ready;

endmodule

/* verilog/path_switch_mux.sv */
`timescale 1ns/100ps

module path_switch_mux import bypass_pkg::*; (
    input  logic       core_clk,
    input  logic       rst,

    input  axis_beat_t in_beat  [2],
    input  logic       in_valid [2],
    output logic       in_ready [2],

    output axis_beat_t out_beat,
    output logic       out_valid,
    input  logic       out_ready
);

    mux_state_e state;
    logic       grant;
    logic       last_q;
    logic       pick;
    logic       cur;

    // round robin so the input not served last wins a tie.
    assign pick = (in_valid[0] && in_valid[1]) ? !last_q : in_valid[1];
    assign cur  = (state == mux_busy) ? grant : pick;

    assign out_beat  = in_beat[cur];
    assign out_valid = in_valid[cur];

    for (genvar i = 0; i < 2; i++) begin : g_ready
        assign in_ready[i] = out_ready && (cur == i);
    end

    // lock as soon as a beat is offered so out_beat cannot change while it waits.
    always_ff @(posedge core_clk) begin
        if (rst) begin
            state  <= mux_idle;
            grant  <= 1'b0;
            last_q <= 1'b0;
        end else if (out_valid) begin
            if (out_ready && out_beat.tlast) begin
                state  <= mux_idle;
                last_q <= cur;
            end else begin
                state <= mux_busy;
                grant <= cur;
            end
        end
    end

    a_out_stable: assert property (@(posedge core_clk) disable iff (rst)
        out_valid && !out_ready |=> out_valid && $stable(out_beat));

endmodule

/* verilog/bypass_top.sv */
`timescale 1ns/100ps

module bypass_top import bypass_pkg::*; (
    input  logic                  core_clk,
    input  logic                  rst,

    input  axis_beat_t            in_beat   [num_ports],
    input  logic                  in_valid  [num_ports],
    output logic                  in_ready  [num_ports],
    output axis_beat_t            out_beat  [num_ports],
    output logic                  out_valid [num_ports],
    input  logic                  out_ready [num_ports],

    input  logic [reg_addr_w-1:0] awaddr,
    input  logic                  awvalid,
    output logic                  awready,
    input  logic [reg_data_w-1:0] wdata,
    input  logic [3:0]            wstrb,
    input  logic                  wvalid,
    output logic                  wready,
    output logic [1:0]            bresp,
    output logic                  bvalid,
    input  logic                  bready,
    input  logic [reg_addr_w-1:0] araddr,
    input  logic                  arvalid,
    output logic                  arready,
    output logic [reg_data_w-1:0] rdata,
    output logic [1:0]            rresp,
    output logic                  rvalid,
    input  logic                  rready
);

    bypass_cfg_t          cfg;
    logic [num_ports-1:0] drop_evt, loop_evt;
    axis_beat_t           own_beat [num_ports], cross_beat [num_ports];
    logic                 own_valid [num_ports], cross_valid [num_ports];
    logic                 own_ready [num_ports], cross_ready [num_ports];
    axis_beat_t           mux_beat  [num_ports][2];
    logic                 mux_valid [num_ports][2];
    logic                 mux_ready [num_ports][2];

    // ------------------------------------------------------------
    // path i own goes to mux i input 0, cross goes to mux 1-i input 1.
    // ------------------------------------------------------------
    for (genvar i = 0; i < num_ports; i++) begin : g_port
        bypass_path u_path (
            .core_clk, .rst, .cfg,
            .in_beat     (in_beat[i]),     .in_valid    (in_valid[i]),
            .in_ready    (in_ready[i]),
            .own_beat    (own_beat[i]),    .own_valid   (own_valid[i]),
            .own_ready   (own_ready[i]),
            .cross_beat  (cross_beat[i]),  .cross_valid (cross_valid[i]),
            .cross_ready (cross_ready[i]),
            .drop_evt    (drop_evt[i]),    .loop_evt    (loop_evt[i])
        );

        assign mux_beat[i][0]        = own_beat[i];
        assign mux_valid[i][0]       = own_valid[i];
        assign own_ready[i]          = mux_ready[i][0];
        assign mux_beat[i][1]        = cross_beat[1-i];
        assign mux_valid[i][1]       = cross_valid[1-i];
        assign cross_ready[1-i]      = mux_ready[i][1];

        path_switch_mux u_mux (
            .core_clk, .rst,
            .in_beat   (mux_beat[i]),  .in_valid  (mux_valid[i]), .in_ready  (mux_ready[i]),
            .out_beat  (out_beat[i]),  .out_valid (out_valid[i]), .out_ready (out_ready[i])
        );
    end

    bypass_regs u_regs (
        .core_clk, .rst,
        .awaddr, .awvalid, .awready, .wdata, .wstrb, .wvalid, .wready,
        .bresp, .bvalid, .bready,
        .araddr, .arvalid, .arready, .rdata, .rresp, .rvalid, .rready,
        .drop_evt, .loop_evt, .cfg
    );

endmodule

/* sim/bypass_tb.sv */
`timescale 1ns/100ps

module bypass_tb import bypass_pkg::*; ();

    localparam int exp_depth = 512;

    logic                  core_clk;
    logic                  rst;
    axis_beat_t            in_beat   [num_ports];
    logic                  in_valid  [num_ports];
    logic                  in_ready  [num_ports];
    axis_beat_t            out_beat  [num_ports];
    logic                  out_valid [num_ports];
    logic                  out_ready [num_ports];
    logic [reg_addr_w-1:0] awaddr;
    logic                  awvalid;
    logic                  awready;
    logic [reg_data_w-1:0] wdata;
    logic [3:0]            wstrb;
    logic                  wvalid;
    logic                  wready;
    logic [1:0]            bresp;
    logic                  bvalid;
    logic                  bready;
    logic [reg_addr_w-1:0] araddr;
    logic                  arvalid;
    logic                  arready;
    logic [reg_data_w-1:0] rdata;
    logic [1:0]            rresp;
    logic                  rvalid;
    logic                  rready;

    integer     seed = 32'hbb95;
    int         errors = 0;
    string      test_name = "reset";
    int         rdy_mode = 0;
    logic       cur_switch = 1'b0;
    logic       cur_loop = 1'b0;
    axis_beat_t exp_q [num_ports][exp_depth];
    int         exp_wr [num_ports] = '{0, 0};
    int         exp_rd [num_ports] = '{0, 0};
    int         exp_drop [num_ports] = '{0, 0};
    int         exp_loop [num_ports] = '{0, 0};

    bypass_top UUT (.*);

    initial begin
        core_clk = 1'b0;
        forever #5 core_clk = ~core_clk;
    end

    // ------------------------------------------------------------
    // ready pattern, expected-beat pop and checks on the output side.
    // ------------------------------------------------------------
    // mode 0 always ready, 1 random gaps, 2 full stall.
    always @(posedge core_clk) begin
        for (int i = 0; i < num_ports; i++) begin
            case (rdy_mode)
                0:       out_ready[i] <= 1'b1;
                1:       out_ready[i] <= (($random(seed) & 3) != 0);
                default: out_ready[i] <= 1'b0;
            endcase
        end
    end

    always @(posedge core_clk) begin
        for (int i = 0; i < num_ports; i++) begin
            if (!rst && out_valid[i] && out_ready[i]) exp_rd[i] <= exp_rd[i] + 1;
        end
    end

    for (genvar i = 0; i < num_ports; i++) begin : g_chk
        axis_beat_t head;

        assign head = exp_q[i][exp_rd[i] % exp_depth];

        a_expected: assert property (@(posedge core_clk) disable iff (rst)
            out_valid[i] && out_ready[i] |-> exp_rd[i] < exp_wr[i])
        else begin
            errors++;
            $display("port %0d sent a beat that was not expected in test %s", i, test_name);
        end

        a_match: assert property (@(posedge core_clk) disable iff (rst)
            out_valid[i] && out_ready[i] && exp_rd[i] < exp_wr[i] |-> out_beat[i] == head)
        else begin
            errors++;
            $display("mismatch %s port %0d expected %h actual %h", test_name, i,
                $sampled(head), $sampled(out_beat[i]));
        end

        a_stable: assert property (@(posedge core_clk) disable iff (rst)
            out_valid[i] && !out_ready[i] |=> out_valid[i] && $stable(out_beat[i]))
        else begin
            errors++;
            $display("port %0d output beat changed while stalled in test %s", i, test_name);
        end
    end

    // ------------------------------------------------------------
    // register bus tasks.
    // ------------------------------------------------------------
    task automatic write_reg(input logic [reg_addr_w-1:0] addr, input logic [31:0] data);
        int cyc;
        bit got_b;
        @(posedge core_clk);
        awaddr  <= addr;
        awvalid <= 1'b1;
        wdata   <= data;
        wstrb   <= 4'hf;
        wvalid  <= 1'b1;
        bready  <= 1'b1;
        cyc   = 0;
        got_b = 0;
        while (!got_b && cyc < 50) begin
            @(posedge core_clk);
            if (awvalid && awready) awvalid <= 1'b0;
            if (wvalid && wready) wvalid <= 1'b0;
            if (bvalid && bready) begin
                got_b = 1;
                // every write answers OKAY.
                assert (bresp == 2'b00) else begin
                    errors++;
                    $display("mismatch %s bresp expected %h actual %h", test_name, 2'b00,
                        bresp);
                end
            end
            cyc++;
        end
        awvalid <= 1'b0;
        wvalid  <= 1'b0;
        bready  <= 1'b0;
        if (!got_b) begin
            errors++;
            $display("timeout: no write response for address %h", addr);
        end
    endtask

    task automatic read_reg(input logic [reg_addr_w-1:0] addr, output logic [31:0] data);
        int cyc;
        bit done;
        data = '0;
        @(posedge core_clk);
        araddr  <= addr;
        arvalid <= 1'b1;
        cyc  = 0;
        done = 0;
        while (!done && cyc < 50) begin
            @(posedge core_clk);
            done = arvalid && arready;
            cyc++;
        end
        arvalid <= 1'b0;
        rready  <= 1'b1;
        cyc  = 0;
        done = 0;
        while (!done && cyc < 50) begin
            @(posedge core_clk);
            done = rvalid;
            if (done) begin
                data = rdata;
                assert (rresp == 2'b00) else begin
                    errors++;
                    $display("mismatch %s rresp expected %h actual %h", test_name, 2'b00,
                        rresp);
                end
            end
            cyc++;
        end
        rready <= 1'b0;
        if (!done) begin
            errors++;
            $display("timeout: read of address %h got no answer", addr);
        end
    endtask

    task automatic check_reg(input logic [reg_addr_w-1:0] addr, input logic [31:0] exp);
        logic [31:0] val;
        read_reg(addr, val);
        assert (val == exp) else begin
            errors++;
            $display("mismatch %s reg %h expected %h actual %h", test_name, addr, exp, val);
        end
    endtask

    task automatic set_config(input logic [1:0] value);
        write_reg(reg_config, {30'd0, value});
        cur_switch = value[0];
        cur_loop   = value[1];
    endtask

    task automatic check_counters();
        check_reg(reg_drop0, exp_drop[0]);
        check_reg(reg_drop1, exp_drop[1]);
        check_reg(reg_loop0, exp_loop[0]);
        check_reg(reg_loop1, exp_loop[1]);
    endtask

    // ------------------------------------------------------------
    // stream stimulus and prediction.
    // ------------------------------------------------------------
    // output port a packet should leave on, or -1 when it is discarded.
    function automatic int route(input int p, input port_t dest);
        if (dest == port_drop) return -1;
        if (cur_loop && dest == port_t'(p)) return -1;
        return cur_switch ? 1 - p : p;
    endfunction

    task automatic send_pkt(input int p, input int nbeats, input port_t dest);
        axis_beat_t b;
        axis_beat_t e;
        int         dst;
        int         cyc;
        bit         xfer;
        dst = route(p, dest);
        if (dest == port_drop) exp_drop[p]++;
        else if (cur_loop && dest == port_t'(p)) exp_loop[p]++;
        @(posedge core_clk);
        for (int k = 0; k < nbeats; k++) begin
            b.tdata = {$random(seed), $random(seed)};
            b.tlast = (k == nbeats - 1);
            b.tkeep = b.tlast ? (8'hff >> ($random(seed) & 7)) : 8'hff;
            b.tid   = port_t'(p);
            b.tdest = dest;
            if (dst >= 0) begin
                e       = b;
                e.tdest = b.tid;
                exp_q[dst][exp_wr[dst] % exp_depth] = e;
                exp_wr[dst]++;
            end
            in_beat[p]  <= b;
            in_valid[p] <= 1'b1;
            cyc  = 0;
            xfer = 0;
            while (!xfer && cyc < 200) begin
                @(posedge core_clk);
                xfer = in_ready[p];
                cyc++;
            end
            if (!xfer) begin
                errors++;
                $display("timeout: port %0d input never accepted a beat in test %s",
                    p, test_name);
            end
        end
        in_valid[p] <= 1'b0;
    endtask

    task automatic send_burst(input int p, input int npkt, input port_t dest);
        for (int k = 0; k < npkt; k++) send_pkt(p, 1 + (k % 5), dest);
    endtask

    task automatic wait_drain();
        int cyc;
        cyc = 0;
        while ((exp_rd[0] != exp_wr[0] || exp_rd[1] != exp_wr[1]) && cyc < 3000) begin
            @(posedge core_clk);
            cyc++;
        end
        if (exp_rd[0] != exp_wr[0] || exp_rd[1] != exp_wr[1]) begin
            errors++;
            $display("timeout: expected beats never left the outputs in test %s", test_name);
        end
        // room for late or extra beats to show up.
        repeat (8) @(posedge core_clk);
    endtask

    // ------------------------------------------------------------
    // test sequence.
    // ------------------------------------------------------------
    initial begin
        rst     = 1'b1;
        awaddr  = '0;
        awvalid = 1'b0;
        wdata   = '0;
        wstrb   = '0;
        wvalid  = 1'b0;
        bready  = 1'b0;
        araddr  = '0;
        arvalid = 1'b0;
        rready  = 1'b0;
        for (int i = 0; i < num_ports; i++) begin
            in_beat[i]   = '0;
            in_valid[i]  = 1'b0;
            out_ready[i] = 1'b1;
        end
        repeat (2) @(posedge core_clk);
        rst <= 1'b0;

        test_name = "regs";
        set_config(2'b11);
        check_reg(reg_config, 32'd3);
        set_config(2'b00);
        check_reg(reg_config, 32'd0);
        write_reg(reg_drop0, 32'h1234);
        write_reg(reg_loop1, 32'hff);
        check_counters();
        check_reg(5'h14, 32'd0);
        check_reg(5'h1c, 32'd0);

        test_name = "drop";
        fork
            begin
                send_pkt(0, 3, port_drop);
                send_pkt(0, 2, 2'd1);
                send_pkt(0, 1, port_drop);
                send_pkt(0, 4, port_drop);
            end
            begin
                send_pkt(1, 2, port_drop);
                send_pkt(1, 3, 2'd0);
                send_pkt(1, 5, port_drop);
            end
        join
        wait_drain();
        check_counters();

        test_name = "pass";
        fork
            send_burst(0, 8, 2'd1);
            send_burst(1, 8, 2'd2);
        join
        wait_drain();

        test_name = "loop";
        set_config(2'b10);
        fork
            begin
                send_pkt(0, 3, 2'd0);
                send_pkt(0, 2, 2'd1);
                send_pkt(0, 1, 2'd0);
            end
            begin
                send_pkt(1, 4, 2'd1);
                send_pkt(1, 2, 2'd0);
            end
        join
        wait_drain();
        check_counters();
        set_config(2'b00);
        fork
            send_burst(0, 3, 2'd0);
            send_burst(1, 3, 2'd1);
        join
        wait_drain();
        check_counters();

        test_name = "switch";
        set_config(2'b01);
        fork
            send_burst(0, 8, 2'd1);
            send_burst(1, 8, 2'd0);
        join
        wait_drain();

        test_name = "backpressure";
        rdy_mode <= 1;
        fork
            send_burst(0, 10, 2'd2);
            send_burst(1, 10, 2'd0);
        join
        wait_drain();
        // long stall fills both FIFOs before the outputs open again.
        rdy_mode <= 2;
        fork
            send_burst(0, 8, 2'd1);
            send_burst(1, 8, 2'd1);
            begin
                repeat (80) @(posedge core_clk);
                rdy_mode <= 1;
            end
        join
        wait_drain();
        rdy_mode <= 0;
        check_counters();

        $display("errors: %0d", errors);
        if (errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

/* bypass_top.f */
verilog/bypass_pkg.sv
verilog/bypass_regs.sv
verilog/pkt_drop.sv
verilog/pkt_fifo.sv
verilog/bypass_path.sv
verilog/path_switch_mux.sv
verilog/bypass_top.sv
sim/bypass_tb.sv
